// ==== filelist.f ====
+incdir+source
source/cpuPkg.sv
source/phaseSequencer.sv
source/pcCounter.sv
source/aluGroupDecoder.sv
source/loadStoreDecoder.sv
source/jumpDecoder.sv
source/opxMultiplexer.sv
source/controlUnit.sv
tb/controlUnitTb.sv

// ==== tb/controlUnitTb.sv ====
`include "cpuSettings.svh"

module controlUnitTb;
	timeunit 1ns;
	timeprecision 100ps;
	import cpuPkg::*;

	localparam int WAIT_LIMIT = 16; // cycles allowed in any wait loop.

	// one instruction with its flags and expected execute codes.
	typedef struct {
		string                  name;
		logic [`WORD_WIDTH-1:0] word;
		logic                   zero;
		logic                   carry;
		logic [`PC_WIDTH-1:0]   nextPc;
		logic [`ALU_OPX_W-1:0]  aluOpx;
		logic [`SEL3_W-1:0]     alubSrcx;
		logic [`SEL2_W-1:0]     regaAddrx;
		logic                   regaWen;
		logic                   rdx;
		logic                   wrx;
		logic                   bytex;
		logic [`SEL2_W-1:0]     regaByteEnx;
		logic [`SEL2_W-1:0]     addrBusx;
		logic [`SEL3_W-1:0]     aluaSrcx;
		logic [`SEL2_W-1:0]     dataBusx;
		logic                   regaEn;
		logic [`SEL2_W-1:0]     regaDinx;
		logic                   regbEn;
		logic                   regbWen;
		logic [`SEL3_W-1:0]     regbAddrx;
		logic [`SEL2_W-1:0]     regbByteEnx;
	} testRow;

	logic                   CLK = 1'b0;
	logic                   rstN;
	logic [`WORD_WIDTH-1:0] instrIn;
	logic                   memReady;
	logic                   zeroFlag;
	logic                   carryFlag;
	logic [`PC_WIDTH-1:0]   pc;
	logic                   fetch, decode, execute, commit;
	logic                   memRead, memWrite;
	logic [`SEL2_W-1:0]     addrBusx, dataBusx, regaAddrx, regaByteEnx, regaDinx, regbByteEnx;
	logic [`ALU_OPX_W-1:0]  aluOpx;
	logic [`SEL3_W-1:0]     aluaSrcx, alubSrcx, regbAddrx;
	logic                   bytex, rdx, wrx, regaEn, regaWen, regbEn, regbWen;

	testRow               rows[$];
	logic [`PC_WIDTH-1:0] lastPc;
	logic [31:0]          junk;

	controlUnit u_controlUnit (.*);

	always #4 CLK = ~CLK;

	task automatic stopWithError(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkCode(input string test, input string what,
		input logic [`ALU_OPX_W-1:0] expected, input logic [`ALU_OPX_W-1:0] actual);
		if (actual !== expected)
			stopWithError($sformatf("Fail %s %s: expected %h, actual %h",
				test, what, expected, actual));
	endtask

	task automatic checkFlag(input string test, input string what,
		input logic expected, input logic actual);
		if (actual !== expected)
			stopWithError($sformatf("Fail %s %s: expected %b, actual %b",
				test, what, expected, actual));
	endtask

	task automatic checkPc(input string test, input string what,
		input logic [`PC_WIDTH-1:0] expected, input logic [`PC_WIDTH-1:0] actual);
		if (actual !== expected)
			stopWithError($sformatf("Fail %s %s: expected %h, actual %h",
				test, what, expected, actual));
	endtask

	task automatic checkInstr(input string test, input instrWord expected,
		input instrWord actual);
		if (actual.raw !== expected.raw)
			stopWithError($sformatf("Fail %s instr: expected %h, actual %h",
				test, expected.raw, actual.raw));
	endtask

	// lands 1 ns after the rising edge, where inputs change.
	task automatic nextCycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic runRow(input testRow row);
		int memDelay;
		int cycles;
		bit isMem;
		isMem = row.rdx || row.wrx;
		zeroFlag = row.zero;
		carryFlag = row.carry;
		memDelay = $urandom % 4;
		cycles = 0;
		do begin
			junk = $urandom;
			memReady = (cycles >= memDelay);
			instrIn = memReady ? row.word : junk[`WORD_WIDTH-1:0]; // garbage until ready.
			#3;
			checkFlag(row.name, "fetch", 1'b1, fetch);
			checkFlag(row.name, "memRead in fetch", 1'b1, memRead);
			checkFlag(row.name, "memWrite in fetch", 1'b0, memWrite);
			nextCycle();
			cycles++;
			if (cycles > WAIT_LIMIT)
				stopWithError($sformatf("%s: timed out waiting for decode", row.name));
		end while (!decode);

		memReady = 1'b0;
		instrIn = junk[`WORD_WIDTH-1:0];
		#3;
		checkInstr(row.name, row.word, u_controlUnit.instr);
		checkFlag(row.name, "memRead in decode", 1'b0, memRead);
		checkFlag(row.name, "memWrite in decode", 1'b0, memWrite);
		checkCode(row.name, "addrBusx after fetch", `ADDR_BUSX_PC_A, addrBusx);
		nextCycle();
		checkFlag(row.name, "execute after decode", 1'b1, execute);

		// only load/store waits on memory here.
		memDelay = isMem ? $urandom % 4 : 0;
		cycles = 0;
		do begin
			memReady = isMem && (cycles >= memDelay);
			#3;
			checkFlag(row.name, "execute", 1'b1, execute);
			checkCode(row.name, "aluOpx", row.aluOpx, aluOpx);
			checkCode(row.name, "alubSrcx", row.alubSrcx, alubSrcx);
			checkCode(row.name, "regaAddrx", row.regaAddrx, regaAddrx);
			checkCode(row.name, "regaByteEnx", row.regaByteEnx, regaByteEnx);
			checkCode(row.name, "addrBusx", row.addrBusx, addrBusx);
			checkCode(row.name, "aluaSrcx", row.aluaSrcx, aluaSrcx);
			checkCode(row.name, "dataBusx", row.dataBusx, dataBusx);
			checkCode(row.name, "regaDinx", row.regaDinx, regaDinx);
			checkCode(row.name, "regbAddrx", row.regbAddrx, regbAddrx);
			checkCode(row.name, "regbByteEnx", row.regbByteEnx, regbByteEnx);
			checkFlag(row.name, "regaWen", row.regaWen, regaWen);
			checkFlag(row.name, "regaEn", row.regaEn, regaEn);
			checkFlag(row.name, "regbEn", row.regbEn, regbEn);
			checkFlag(row.name, "regbWen", row.regbWen, regbWen);
			checkFlag(row.name, "rdx", row.rdx, rdx);
			checkFlag(row.name, "wrx", row.wrx, wrx);
			checkFlag(row.name, "bytex", row.bytex, bytex);
			checkFlag(row.name, "memRead in execute", row.rdx, memRead);
			checkFlag(row.name, "memWrite in execute", row.wrx, memWrite);
			nextCycle();
			cycles++;
			if (cycles > WAIT_LIMIT)
				stopWithError($sformatf("%s: timed out waiting for commit", row.name));
		end while (!commit);
		if (cycles != memDelay + 1)
			stopWithError($sformatf("Fail %s execute cycles: expected %0d, actual %0d",
				row.name, memDelay + 1, cycles));

		memReady = 1'b0;
		#3;
		checkFlag(row.name, "memRead in commit", 1'b0, memRead);
		checkFlag(row.name, "memWrite in commit", 1'b0, memWrite);
		checkPc(row.name, "pc before commit", lastPc, pc);
		nextCycle();
		checkFlag(row.name, "fetch after commit", 1'b1, fetch);
		checkPc(row.name, "pc after commit", row.nextPc, pc);
		lastPc = row.nextPc;
	endtask

	task automatic fillRows();
		// arithmetic-logic, flags set to show they are ignored.
		rows.push_back('{"aluAdd", 16'hC428, 1'b1, 1'b1, 16'd1,
			`ALU_OPX_ADD, `ALUB_SRCX_REG_B, `REGA_ADDRX_ARGA, `REG_WEN_WRITE,
			`RDX_NONE, `WRX_NONE, `BYTEX_WORD, `REG_BYTE_ENX_BOTH, `ADDR_BUSX_PC_A,
			`ALUA_SRCX_REG_A, `DATA_BUSX_ALU_OUT, `REG_EN_ENABLE, `REGA_DINX_ALU_OUT,
			`REG_EN_ENABLE, `REG_WEN_NONE, `REGB_ADDRX_ARGB, `REG_BYTE_ENX_BOTH});
		rows.push_back('{"aluCmpImm", 16'hDA70, 1'b0, 1'b0, 16'd2,
			`ALU_OPX_CMP, `ALUB_SRCX_IMM, `REGA_ADDRX_ARGA, `REG_WEN_NONE,
			`RDX_NONE, `WRX_NONE, `BYTEX_WORD, `REG_BYTE_ENX_BOTH, `ADDR_BUSX_PC_A,
			`ALUA_SRCX_REG_A, `DATA_BUSX_ALU_OUT, `REG_EN_ENABLE, `REGA_DINX_ALU_OUT,
			`REG_EN_NONE, `REG_WEN_NONE, `REGB_ADDRX_ARGB, `REG_BYTE_ENX_BOTH});
		rows.push_back('{"aluSubNoWrite", 16'hC914, 1'b0, 1'b0, 16'd3,
			`ALU_OPX_SUB, `ALUB_SRCX_REG_B, `REGA_ADDRX_ARGA, `REG_WEN_NONE,
			`RDX_NONE, `WRX_NONE, `BYTEX_WORD, `REG_BYTE_ENX_BOTH, `ADDR_BUSX_PC_A,
			`ALUA_SRCX_REG_A, `DATA_BUSX_ALU_OUT, `REG_EN_ENABLE, `REGA_DINX_ALU_OUT,
			`REG_EN_ENABLE, `REG_WEN_NONE, `REGB_ADDRX_ARGB, `REG_BYTE_ENX_BOTH});
		// load/store.
		rows.push_back('{"loadWord", 16'h40A0, 1'b0, 1'b0, 16'd4,
			`ALU_OPX_ADD, `ALUB_SRCX_IMM, `REGA_ADDRX_ARGA, `REG_WEN_WRITE,
			`RDX_READ, `WRX_NONE, `BYTEX_WORD, `REG_BYTE_ENX_BOTH, `ADDR_BUSX_REGB_DOUT,
			`ALUA_SRCX_REG_B, `DATA_BUSX_REGA_DOUT, `REG_EN_ENABLE, `REGA_DINX_DIN,
			`REG_EN_ENABLE, `REG_WEN_NONE, `REGB_ADDRX_ARGB, `REG_BYTE_ENX_NONE});
		rows.push_back('{"storeByteLow", 16'h7534, 1'b1, 1'b0, 16'd5,
			`ALU_OPX_ADD, `ALUB_SRCX_IMM, `REGA_ADDRX_ARGA, `REG_WEN_NONE,
			`RDX_NONE, `WRX_WRITE, `BYTEX_BYTE, `REG_BYTE_ENX_NONE, `ADDR_BUSX_ALU_OUT,
			`ALUA_SRCX_REG_B, `DATA_BUSX_REGA_DOUT, `REG_EN_ENABLE, `REGA_DINX_DIN,
			`REG_EN_ENABLE, `REG_WEN_WRITE, `REGB_ADDRX_ARGB, `REG_BYTE_ENX_BOTH});
		rows.push_back('{"loadByteHigh", 16'h5A1F, 1'b0, 1'b1, 16'd6,
			`ALU_OPX_ADD, `ALUB_SRCX_IMM, `REGA_ADDRX_ARGA, `REG_WEN_WRITE,
			`RDX_READ, `WRX_NONE, `BYTEX_BYTE, `REG_BYTE_ENX_HIGH, `ADDR_BUSX_ALU_OUT,
			`ALUA_SRCX_REG_B, `DATA_BUSX_REGA_DOUT, `REG_EN_ENABLE, `REGA_DINX_DIN,
			`REG_EN_ENABLE, `REG_WEN_NONE, `REGB_ADDRX_ARGB, `REG_BYTE_ENX_NONE});
		rows.push_back('{"storeWord", 16'h62E0, 1'b0, 1'b0, 16'd7,
			`ALU_OPX_ADD, `ALUB_SRCX_IMM, `REGA_ADDRX_ARGA, `REG_WEN_NONE,
			`RDX_NONE, `WRX_WRITE, `BYTEX_WORD, `REG_BYTE_ENX_NONE, `ADDR_BUSX_REGB_DOUT,
			`ALUA_SRCX_REG_B, `DATA_BUSX_REGA_DOUT, `REG_EN_ENABLE, `REGA_DINX_DIN,
			`REG_EN_ENABLE, `REG_WEN_NONE, `REGB_ADDRX_ARGB, `REG_BYTE_ENX_NONE});
		// jumps, target is pc plus one plus offset.
		rows.push_back('{"jumpAlways", 16'h8005, 1'b0, 1'b0, 16'd13,
			`ALU_OPX_ADD, `ALUB_SRCX_IMM, `REGA_ADDRX_ARGA, `REG_WEN_NONE,
			`RDX_NONE, `WRX_NONE, `BYTEX_WORD, `REG_BYTE_ENX_BOTH, `ADDR_BUSX_PC_A,
			`ALUA_SRCX_PC, `DATA_BUSX_REGA_DOUT, `REG_EN_NONE, `REGA_DINX_PC,
			`REG_EN_NONE, `REG_WEN_NONE, `REGB_ADDRX_ARGB, `REG_BYTE_ENX_BOTH});
		rows.push_back('{"jumpZeroLink", 16'h9FFD, 1'b1, 1'b0, 16'd11,
			`ALU_OPX_ADD, `ALUB_SRCX_IMM, `REGA_ADDRX_LINK, `REG_WEN_WRITE,
			`RDX_NONE, `WRX_NONE, `BYTEX_WORD, `REG_BYTE_ENX_BOTH, `ADDR_BUSX_PC_A,
			`ALUA_SRCX_PC, `DATA_BUSX_REGA_DOUT, `REG_EN_ENABLE, `REGA_DINX_PC,
			`REG_EN_NONE, `REG_WEN_NONE, `REGB_ADDRX_ARGB, `REG_BYTE_ENX_BOTH});
		rows.push_back('{"jumpZeroNotTaken", 16'h9010, 1'b0, 1'b1, 16'd12,
			`ALU_OPX_ADD, `ALUB_SRCX_IMM, `REGA_ADDRX_ARGA, `REG_WEN_NONE,
			`RDX_NONE, `WRX_NONE, `BYTEX_WORD, `REG_BYTE_ENX_BOTH, `ADDR_BUSX_PC_A,
			`ALUA_SRCX_PC, `DATA_BUSX_REGA_DOUT, `REG_EN_NONE, `REGA_DINX_PC,
			`REG_EN_NONE, `REG_WEN_NONE, `REGB_ADDRX_ARGB, `REG_BYTE_ENX_BOTH});
		rows.push_back('{"jumpCarry", 16'hA002, 1'b0, 1'b1, 16'd15,
			`ALU_OPX_ADD, `ALUB_SRCX_IMM, `REGA_ADDRX_ARGA, `REG_WEN_NONE,
			`RDX_NONE, `WRX_NONE, `BYTEX_WORD, `REG_BYTE_ENX_BOTH, `ADDR_BUSX_PC_A,
			`ALUA_SRCX_PC, `DATA_BUSX_REGA_DOUT, `REG_EN_NONE, `REGA_DINX_PC,
			`REG_EN_NONE, `REG_WEN_NONE, `REGB_ADDRX_ARGB, `REG_BYTE_ENX_BOTH});
		rows.push_back('{"jumpNotZeroNotTaken", 16'hB7FF, 1'b1, 1'b0, 16'd16,
			`ALU_OPX_ADD, `ALUB_SRCX_IMM, `REGA_ADDRX_ARGA, `REG_WEN_NONE,
			`RDX_NONE, `WRX_NONE, `BYTEX_WORD, `REG_BYTE_ENX_BOTH, `ADDR_BUSX_PC_A,
			`ALUA_SRCX_PC, `DATA_BUSX_REGA_DOUT, `REG_EN_NONE, `REGA_DINX_PC,
			`REG_EN_NONE, `REG_WEN_NONE, `REGB_ADDRX_ARGB, `REG_BYTE_ENX_BOTH});
		// system group, idle codes only.
		rows.push_back('{"systemNop", 16'h0000, 1'b0, 1'b0, 16'd17,
			`ALU_OPX_MOV, `ALUB_SRCX_REG_B, `REGA_ADDRX_ARGA, `REG_WEN_NONE,
			`RDX_NONE, `WRX_NONE, `BYTEX_WORD, `REG_BYTE_ENX_NONE, `ADDR_BUSX_PC_A,
			`ALUA_SRCX_REG_A, `DATA_BUSX_REGA_DOUT, `REG_EN_NONE, `REGA_DINX_DIN,
			`REG_EN_NONE, `REG_WEN_NONE, `REGB_ADDRX_ARGB, `REG_BYTE_ENX_NONE});
		rows.push_back('{"systemOther", 16'h1234, 1'b1, 1'b1, 16'd18,
			`ALU_OPX_MOV, `ALUB_SRCX_REG_B, `REGA_ADDRX_ARGA, `REG_WEN_NONE,
			`RDX_NONE, `WRX_NONE, `BYTEX_WORD, `REG_BYTE_ENX_NONE, `ADDR_BUSX_PC_A,
			`ALUA_SRCX_REG_A, `DATA_BUSX_REGA_DOUT, `REG_EN_NONE, `REGA_DINX_DIN,
			`REG_EN_NONE, `REG_WEN_NONE, `REGB_ADDRX_ARGB, `REG_BYTE_ENX_NONE});
	endtask

	initial begin
		void'($urandom(32'hd560));
		rstN = 1'b0;
		instrIn = '0;
		memReady = 1'b0;
		zeroFlag = 1'b0;
		carryFlag = 1'b0;
		lastPc = '0;
		junk = '0;
		fillRows();

		repeat (5) @(posedge CLK);
		#1;
		checkFlag("reset", "fetch", 1'b1, fetch);
		checkFlag("reset", "decode", 1'b0, decode);
		checkFlag("reset", "execute", 1'b0, execute);
		checkFlag("reset", "commit", 1'b0, commit);
		checkFlag("reset", "memRead", 1'b1, memRead);
		checkFlag("reset", "memWrite", 1'b0, memWrite);
		checkPc("reset", "pc", '0, pc);
		checkCode("reset", "addrBusx", `ADDR_BUSX_PC_A, addrBusx);
		checkInstr("reset", '0, u_controlUnit.instr);
		rstN = 1'b1;

		foreach (rows[i]) runRow(rows[i]);

		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== source/controlUnit.sv ====
`include "cpuSettings.svh"

module controlUnit (
	input  logic                   CLK,
	input  logic                   rstN,
	input  logic [`WORD_WIDTH-1:0] instrIn,
	input  logic                   memReady,
	input  logic                   zeroFlag,
	input  logic                   carryFlag,
	output logic [`PC_WIDTH-1:0]   pc,
	output logic                   fetch,
	output logic                   decode,
	output logic                   execute,
	output logic                   commit,
	output logic                   memRead,
	output logic                   memWrite,
	output logic [`SEL2_W-1:0]     addrBusx,
	output logic [`ALU_OPX_W-1:0]  aluOpx,
	output logic [`SEL3_W-1:0]     aluaSrcx,
	output logic [`SEL3_W-1:0]     alubSrcx,
	output logic                   bytex,
	output logic [`SEL2_W-1:0]     dataBusx,
	output logic                   rdx,
	output logic                   regaEn,
	output logic                   regaWen,
	output logic [`SEL2_W-1:0]     regaAddrx,
	output logic [`SEL2_W-1:0]     regaByteEnx,
	output logic [`SEL2_W-1:0]     regaDinx,
	output logic                   regbEn,
	output logic                   regbWen,
	output logic [`SEL3_W-1:0]     regbAddrx,
	output logic [`SEL2_W-1:0]     regbByteEnx,
	output logic                   wrx
);

	cpuPkg::instrWord instr;
	logic             jumpTaken;

	logic [`ALU_OPX_W-1:0] aluAluOpx;
	logic [`SEL3_W-1:0]    aluAluaSrcx, aluAlubSrcx, aluRegbAddrx;
	logic [`SEL2_W-1:0]    aluDataBusx, aluRegaAddrx, aluRegaDinx;
	logic                  aluRegaEn, aluRegbEn, aluRegaWen, aluRegbWen;

	logic [`SEL2_W-1:0]    ldsAddrBusx;
	logic [`ALU_OPX_W-1:0] ldsAluOpx;
	logic [`SEL3_W-1:0]    ldsAluaSrcx, ldsAlubSrcx, ldsRegbAddrx;
	logic [`SEL2_W-1:0]    ldsDataBusx, ldsRegaAddrx, ldsRegaDinx;
	logic [`SEL2_W-1:0]    ldsRegaByteEnx, ldsRegbByteEnx;
	logic                  ldsBytex, ldsRdx, ldsWrx;
	logic                  ldsRegaEn, ldsRegaWen, ldsRegbEn, ldsRegbWen;

	logic [`SEL3_W-1:0]    jmpAlubSrcx, jmpRegbAddrx;
	logic [`SEL2_W-1:0]    jmpRegaAddrx;
	logic                  jmpRegaEn, jmpRegaWen, jmpRegbEn;

	phaseSequencer u_phaseSequencer (.*);

	pcCounter u_pcCounter (.*);

	aluGroupDecoder u_aluGroupDecoder (
		.instr(instr), .aluOpx(aluAluOpx), .aluaSrcx(aluAluaSrcx), .alubSrcx(aluAlubSrcx),
		.dataBusx(aluDataBusx), .regaAddrx(aluRegaAddrx), .regaDinx(aluRegaDinx),
		.regaEn(aluRegaEn), .regbAddrx(aluRegbAddrx), .regbEn(aluRegbEn),
		.regaWen(aluRegaWen), .regbWen(aluRegbWen)
	);

	loadStoreDecoder u_loadStoreDecoder (
		.instr(instr), .addrBusx(ldsAddrBusx), .aluOpx(ldsAluOpx),
		.aluaSrcx(ldsAluaSrcx), .alubSrcx(ldsAlubSrcx), .bytex(ldsBytex),
		.dataBusx(ldsDataBusx), .rdx(ldsRdx), .regaEn(ldsRegaEn), .regaWen(ldsRegaWen),
		.regaAddrx(ldsRegaAddrx), .regaByteEnx(ldsRegaByteEnx), .regaDinx(ldsRegaDinx),
		.regbEn(ldsRegbEn), .regbWen(ldsRegbWen), .regbAddrx(ldsRegbAddrx),
		.regbByteEnx(ldsRegbByteEnx), .wrx(ldsWrx)
	);

	jumpDecoder u_jumpDecoder (
		.instr(instr), .zeroFlag(zeroFlag), .carryFlag(carryFlag),
		.alubSrcx(jmpAlubSrcx), .regaAddrx(jmpRegaAddrx), .regbAddrx(jmpRegbAddrx),
		.regaEn(jmpRegaEn), .regaWen(jmpRegaWen), .regbEn(jmpRegbEn),
		.jumpTaken(jumpTaken)
	);

	opxMultiplexer u_opxMultiplexer (.*);

endmodule

// ==== source/opxMultiplexer.sv ====
`include "cpuSettings.svh"

module opxMultiplexer (
	input  logic                  CLK,
	input  logic                  rstN,
	input  cpuPkg::instrWord      instr,
	input  logic                  fetch,

	input  logic [`ALU_OPX_W-1:0] aluAluOpx,
	input  logic [`SEL3_W-1:0]    aluAluaSrcx, aluAlubSrcx, aluRegbAddrx,
	input  logic [`SEL2_W-1:0]    aluDataBusx, aluRegaAddrx, aluRegaDinx,
	input  logic                  aluRegaEn, aluRegbEn, aluRegaWen, aluRegbWen,

	input  logic [`SEL2_W-1:0]    ldsAddrBusx,
	input  logic [`ALU_OPX_W-1:0] ldsAluOpx,
	input  logic [`SEL3_W-1:0]    ldsAluaSrcx, ldsAlubSrcx, ldsRegbAddrx,
	input  logic [`SEL2_W-1:0]    ldsDataBusx, ldsRegaAddrx, ldsRegaDinx,
	input  logic [`SEL2_W-1:0]    ldsRegaByteEnx, ldsRegbByteEnx,
	input  logic                  ldsBytex, ldsRdx, ldsWrx,
	input  logic                  ldsRegaEn, ldsRegaWen, ldsRegbEn, ldsRegbWen,

	input  logic [`SEL3_W-1:0]    jmpAlubSrcx, jmpRegbAddrx,
	input  logic [`SEL2_W-1:0]    jmpRegaAddrx,
	input  logic                  jmpRegaEn, jmpRegaWen, jmpRegbEn,

	output logic [`SEL2_W-1:0]    addrBusx,
	output logic [`ALU_OPX_W-1:0] aluOpx,
	output logic [`SEL3_W-1:0]    aluaSrcx,
	output logic [`SEL3_W-1:0]    alubSrcx,
	output logic                  bytex,
	output logic [`SEL2_W-1:0]    dataBusx,
	output logic                  rdx,
	output logic                  regaEn,
	output logic                  regaWen,
	output logic [`SEL2_W-1:0]    regaAddrx,
	output logic [`SEL2_W-1:0]    regaByteEnx,
	output logic [`SEL2_W-1:0]    regaDinx,
	output logic                  regbEn,
	output logic                  regbWen,
	output logic [`SEL3_W-1:0]    regbAddrx,
	output logic [`SEL2_W-1:0]    regbByteEnx,
	output logic                  wrx
);
	import cpuPkg::*;

	logic [1:0] group;

	assign group = instr.raw[`WORD_WIDTH-1 -: 2];

	always_comb begin
		// idle codes, also the system no-op.
		aluOpx      = `ALU_OPX_MOV;
		aluaSrcx    = `ALUA_SRCX_REG_A;
		alubSrcx    = `ALUB_SRCX_REG_B;
		bytex       = `BYTEX_WORD;
		dataBusx    = `DATA_BUSX_REGA_DOUT;
		rdx         = `RDX_NONE;
		regaEn      = `REG_EN_NONE;
		regaWen     = `REG_WEN_NONE;
		regaAddrx   = `REGA_ADDRX_ARGA;
		regaByteEnx = `REG_BYTE_ENX_NONE;
		regaDinx    = `REGA_DINX_DIN;
		regbEn      = `REG_EN_NONE;
		regbWen     = `REG_WEN_NONE;
		regbAddrx   = `REGB_ADDRX_ARGB;
		regbByteEnx = `REG_BYTE_ENX_NONE;
		wrx         = `WRX_NONE;
		case (group)
			`GROUP_LOAD_STORE: begin
				aluOpx      = ldsAluOpx;
				aluaSrcx    = ldsAluaSrcx;
				alubSrcx    = ldsAlubSrcx;
				bytex       = ldsBytex;
				dataBusx    = ldsDataBusx;
				rdx         = ldsRdx;
				regaEn      = ldsRegaEn;
				regaWen     = ldsRegaWen;
				regaAddrx   = ldsRegaAddrx;
				regaByteEnx = ldsRegaByteEnx;
				regaDinx    = ldsRegaDinx;
				regbEn      = ldsRegbEn;
				regbWen     = ldsRegbWen;
				regbAddrx   = ldsRegbAddrx;
				regbByteEnx = ldsRegbByteEnx;
				wrx         = ldsWrx;
			end
			`GROUP_JUMP: begin
				aluOpx      = `ALU_OPX_ADD; // pc plus offset.
				aluaSrcx    = `ALUA_SRCX_PC;
				alubSrcx    = jmpAlubSrcx;
				regaEn      = jmpRegaEn;
				regaWen     = jmpRegaWen;
				regaAddrx   = jmpRegaAddrx;
				regaByteEnx = `REG_BYTE_ENX_BOTH;
				regaDinx    = `REGA_DINX_PC;
				regbEn      = jmpRegbEn;
				regbAddrx   = jmpRegbAddrx;
				regbByteEnx = `REG_BYTE_ENX_BOTH;
			end
			`GROUP_ARITHMETIC_LOGIC: begin
				aluOpx      = aluAluOpx;
				aluaSrcx    = aluAluaSrcx;
				alubSrcx    = aluAlubSrcx;
				dataBusx    = aluDataBusx;
				regaEn      = aluRegaEn;
				regaWen     = aluRegaWen;
				regaAddrx   = aluRegaAddrx;
				regaByteEnx = `REG_BYTE_ENX_BOTH;
				regaDinx    = aluRegaDinx;
				regbEn      = aluRegbEn;
				regbWen     = aluRegbWen;
				regbAddrx   = aluRegbAddrx;
				regbByteEnx = `REG_BYTE_ENX_BOTH;
			end
			default: ;
		endcase
	end

	// only load/store moves the address bus off the pc.
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			addrBusx <= `ADDR_BUSX_PC_A;
		end else if (fetch || group != `GROUP_LOAD_STORE) begin
			addrBusx <= `ADDR_BUSX_PC_A;
		end else begin
			addrBusx <= ldsAddrBusx;
		end
	end

	assert property (@(posedge CLK) disable iff (!rstN) !(rdx && wrx))
		else $error("read and write selected together");

endmodule

// ==== source/jumpDecoder.sv ====
`include "cpuSettings.svh"

module jumpDecoder (
	input  cpuPkg::instrWord   instr,
	input  logic               zeroFlag,
	input  logic               carryFlag,
	output logic [`SEL3_W-1:0] alubSrcx,
	output logic [`SEL2_W-1:0] regaAddrx,
	output logic [`SEL3_W-1:0] regbAddrx,
	output logic               regaEn,
	output logic               regaWen,
	output logic               regbEn,
	output logic               jumpTaken
);
	import cpuPkg::*;

	logic condMet;

	always_comb begin
		case (instr.jmp.cond)
			`COND_ALWAYS: condMet = 1'b1;
			`COND_ZERO:   condMet = zeroFlag;
			`COND_CARRY:  condMet = carryFlag;
			default:      condMet = !zeroFlag; // not zero.
		endcase
	end

	assign jumpTaken = (instr.jmp.group == `GROUP_JUMP) && condMet;

	// return address goes to the link register.
	assign alubSrcx  = `ALUB_SRCX_IMM;
	assign regaAddrx = instr.jmp.link ? `REGA_ADDRX_LINK : `REGA_ADDRX_ARGA;
	assign regbAddrx = `REGB_ADDRX_ARGB;
	assign regaEn    = instr.jmp.link ? `REG_EN_ENABLE : `REG_EN_NONE;
	assign regaWen   = instr.jmp.link ? `REG_WEN_WRITE : `REG_WEN_NONE;
	assign regbEn    = `REG_EN_NONE;

endmodule

// ==== source/loadStoreDecoder.sv ====
`include "cpuSettings.svh"

module loadStoreDecoder (
	input  cpuPkg::instrWord      instr,
	output logic [`SEL2_W-1:0]    addrBusx,
	output logic [`ALU_OPX_W-1:0] aluOpx,
	output logic [`SEL3_W-1:0]    aluaSrcx,
	output logic [`SEL3_W-1:0]    alubSrcx,
	output logic                  bytex,
	output logic [`SEL2_W-1:0]    dataBusx,
	output logic                  rdx,
	output logic                  regaEn,
	output logic                  regaWen,
	output logic [`SEL2_W-1:0]    regaAddrx,
	output logic [`SEL2_W-1:0]    regaByteEnx,
	output logic [`SEL2_W-1:0]    regaDinx,
	output logic                  regbEn,
	output logic                  regbWen,
	output logic [`SEL3_W-1:0]    regbAddrx,
	output logic [`SEL2_W-1:0]    regbByteEnx,
	output logic                  wrx
);
	import cpuPkg::*;

	logic [`SEL2_W-1:0] byteEn;

	assign byteEn = !instr.ls.byteAccess ? `REG_BYTE_ENX_BOTH :
		instr.ls.highByte ? `REG_BYTE_ENX_HIGH : `REG_BYTE_ENX_LOW;

	// effective address is argB plus offset.
	assign aluOpx   = `ALU_OPX_ADD;
	assign aluaSrcx = `ALUA_SRCX_REG_B;
	assign alubSrcx = `ALUB_SRCX_IMM;
	assign addrBusx = (instr.ls.offset != '0) ? `ADDR_BUSX_ALU_OUT : `ADDR_BUSX_REGB_DOUT;

	assign bytex    = instr.ls.byteAccess ? `BYTEX_BYTE : `BYTEX_WORD;
	assign dataBusx = `DATA_BUSX_REGA_DOUT; // store data.
	assign rdx      = instr.ls.store ? `RDX_NONE : `RDX_READ;
	assign wrx      = instr.ls.store ? `WRX_WRITE : `WRX_NONE;

	assign regaEn      = `REG_EN_ENABLE;
	assign regaWen     = instr.ls.store ? `REG_WEN_NONE : `REG_WEN_WRITE;
	assign regaAddrx   = `REGA_ADDRX_ARGA;
	assign regaByteEnx = instr.ls.store ? `REG_BYTE_ENX_NONE : byteEn;
	assign regaDinx    = `REGA_DINX_DIN;

	// base register written back on post-increment.
	assign regbEn      = `REG_EN_ENABLE;
	assign regbWen     = instr.ls.postInc ? `REG_WEN_WRITE : `REG_WEN_NONE;
	assign regbAddrx   = `REGB_ADDRX_ARGB;
	assign regbByteEnx = instr.ls.postInc ? `REG_BYTE_ENX_BOTH : `REG_BYTE_ENX_NONE;

endmodule

// ==== source/aluGroupDecoder.sv ====
`include "cpuSettings.svh"

module aluGroupDecoder (
	input  cpuPkg::instrWord        instr,
	output logic [`ALU_OPX_W-1:0]   aluOpx,
	output logic [`SEL3_W-1:0]      aluaSrcx,
	output logic [`SEL3_W-1:0]      alubSrcx,
	output logic [`SEL2_W-1:0]      dataBusx,
	output logic [`SEL2_W-1:0]      regaAddrx,
	output logic [`SEL2_W-1:0]      regaDinx,
	output logic                    regaEn,
	output logic [`SEL3_W-1:0]      regbAddrx,
	output logic                    regbEn,
	output logic                    regaWen,
	output logic                    regbWen
);
	import cpuPkg::*;

	logic noRegaWrite;

	// compare only sets flags.
	assign noRegaWrite = instr.alu.noWrite || (instr.alu.aluOp == `ALU_OPX_CMP);

	assign aluOpx    = instr.alu.aluOp;
	assign aluaSrcx  = `ALUA_SRCX_REG_A;
	assign alubSrcx  = instr.alu.immB ? `ALUB_SRCX_IMM : `ALUB_SRCX_REG_B;
	assign dataBusx  = `DATA_BUSX_ALU_OUT;
	assign regaAddrx = `REGA_ADDRX_ARGA;
	assign regaDinx  = `REGA_DINX_ALU_OUT;
	assign regaEn    = `REG_EN_ENABLE;
	assign regbAddrx = `REGB_ADDRX_ARGB;
	assign regbEn    = instr.alu.immB ? `REG_EN_NONE : `REG_EN_ENABLE; // no read for immediate.
	assign regaWen   = noRegaWrite ? `REG_WEN_NONE : `REG_WEN_WRITE;
	assign regbWen   = `REG_WEN_NONE;

endmodule

// ==== source/pcCounter.sv ====
`include "cpuSettings.svh"

module pcCounter (
	input  logic                 CLK,
	input  logic                 rstN,
	input  logic                 commit,
	input  logic                 jumpTaken,
	input  cpuPkg::instrWord     instr,
	output logic [`PC_WIDTH-1:0] pc
);
	import cpuPkg::*;

	logic [`PC_WIDTH-1:0] offset;
	logic [`PC_WIDTH-1:0] nextPc;

	// sign-extended jump offset.
	assign offset = {{(`PC_WIDTH - 11){instr.jmp.offset[10]}}, instr.jmp.offset};

	assign nextPc = jumpTaken ? pc + 1'b1 + offset : pc + 1'b1;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (commit) begin
			pc <= nextPc;
		end
	end

	// pc moves only on the edge that ends commit.
	assert property (@(posedge CLK) disable iff (!rstN) $changed(pc) |-> $past(commit))
		else $error("pc changed outside commit");

endmodule

// ==== source/phaseSequencer.sv ====
`include "cpuSettings.svh"

module phaseSequencer (
	input  logic                   CLK,
	input  logic                   rstN,
	input  logic [`WORD_WIDTH-1:0] instrIn,
	input  logic                   memReady,
	input  logic                   rdx,
	input  logic                   wrx,
	output cpuPkg::instrWord       instr,
	output logic                   fetch,
	output logic                   decode,
	output logic                   execute,
	output logic                   commit,
	output logic                   memRead,
	output logic                   memWrite
);
	import cpuPkg::*;

	localparam logic [1:0] PH_FETCH   = 2'd0;
	localparam logic [1:0] PH_DECODE  = 2'd1;
	localparam logic [1:0] PH_EXECUTE = 2'd2;
	localparam logic [1:0] PH_COMMIT  = 2'd3;

	logic [1:0] phase;
	logic       memAccess;

	assign memAccess = (rdx == `RDX_READ) || (wrx == `WRX_WRITE);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			phase <= PH_FETCH;
		end else begin
			case (phase)
				PH_FETCH:   if (memReady) phase <= PH_DECODE;
				PH_DECODE:  phase <= PH_EXECUTE;
				PH_EXECUTE: if (!memAccess || memReady) phase <= PH_COMMIT; // load/store waits.
				default:    phase <= PH_FETCH;
			endcase
		end
	end

	// instruction register, system no-op out of reset.
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			instr <= '0;
		end else if (fetch && memReady) begin
			instr.raw <= instrIn;
		end
	end

	assign fetch   = (phase == PH_FETCH);
	assign decode  = (phase == PH_DECODE);
	assign execute = (phase == PH_EXECUTE);
	assign commit  = (phase == PH_COMMIT);

	assign memRead  = fetch || (execute && rdx == `RDX_READ);
	assign memWrite = execute && (wrx == `WRX_WRITE);

	assert property (@(posedge CLK) disable iff (!rstN)
		$onehot({fetch, decode, execute, commit}))
		else $error("phase strobes not one-hot");

endmodule

// ==== source/cpuPkg.sv ====
`include "cpuSettings.svh"

package cpuPkg;

	typedef struct packed {
		logic [1:0] group;
		logic [3:0] aluOp;
		logic       immB;    // argB field is the immediate.
		logic       noWrite;
		logic [2:0] argA;
		logic [2:0] argB;
		logic [1:0] spare;
	} aluFormat;

	typedef struct packed {
		logic [1:0] group;
		logic       store;
		logic       byteAccess;
		logic       highByte;
		logic       postInc;
		logic [2:0] argA;
		logic [2:0] argB;
		logic [3:0] offset;
	} lsFormat;

	typedef struct packed {
		logic [1:0]         group;
		logic [1:0]         cond;
		logic               link;
		logic signed [10:0] offset; // relative to pc plus one.
	} jmpFormat;

	// one fetched word, read as the format its group names.
	typedef union packed {
		logic [`WORD_WIDTH-1:0] raw;
		aluFormat               alu;
		lsFormat                ls;
		jmpFormat               jmp;
	} instrWord;

endpackage

// ==== source/cpuSettings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define WORD_WIDTH 16
`define PC_WIDTH   16

// instruction groups, top two bits of the word.
`define GROUP_SYSTEM           2'b00
`define GROUP_LOAD_STORE       2'b01
`define GROUP_JUMP             2'b10
`define GROUP_ARITHMETIC_LOGIC 2'b11

// select code widths.
`define ALU_OPX_W 4
`define SEL3_W    3
`define SEL2_W    2

`define ALU_OPX_MOV 4'd0
`define ALU_OPX_ADD 4'd1
`define ALU_OPX_SUB 4'd2
`define ALU_OPX_AND 4'd3
`define ALU_OPX_OR  4'd4
`define ALU_OPX_XOR 4'd5
`define ALU_OPX_CMP 4'd6

`define ALUA_SRCX_REG_A 3'd0
`define ALUA_SRCX_REG_B 3'd1
`define ALUA_SRCX_IMM   3'd2
`define ALUA_SRCX_PC    3'd3

`define ALUB_SRCX_REG_A 3'd0
`define ALUB_SRCX_REG_B 3'd1
`define ALUB_SRCX_IMM   3'd2
`define ALUB_SRCX_PC    3'd3

`define DATA_BUSX_REGA_DOUT 2'd0
`define DATA_BUSX_ALU_OUT   2'd1
`define DATA_BUSX_PC        2'd2

`define ADDR_BUSX_PC_A      2'd0
`define ADDR_BUSX_ALU_OUT   2'd1
`define ADDR_BUSX_REGB_DOUT 2'd2

`define REGA_ADDRX_ARGA 2'd0
`define REGA_ADDRX_ARGB 2'd1
`define REGA_ADDRX_LINK 2'd2

`define REGB_ADDRX_ARGB 3'd0
`define REGB_ADDRX_ARGA 3'd1
`define REGB_ADDRX_LINK 3'd2

`define REGA_DINX_DIN     2'd0
`define REGA_DINX_ALU_OUT 2'd1
`define REGA_DINX_PC      2'd2

`define REG_BYTE_ENX_NONE 2'd0
`define REG_BYTE_ENX_LOW  2'd1
`define REG_BYTE_ENX_HIGH 2'd2
`define REG_BYTE_ENX_BOTH 2'd3

`define BYTEX_WORD    1'b0
`define BYTEX_BYTE    1'b1
`define RDX_NONE      1'b0
`define RDX_READ      1'b1
`define WRX_NONE      1'b0
`define WRX_WRITE     1'b1
`define REG_EN_NONE   1'b0
`define REG_EN_ENABLE 1'b1
`define REG_WEN_NONE  1'b0
`define REG_WEN_WRITE 1'b1

// jump conditions.
`define COND_ALWAYS   2'd0
`define COND_ZERO     2'd1
`define COND_CARRY    2'd2
`define COND_NOT_ZERO 2'd3

`endif
